/* build.f */
+incdir+tb
hw/soc_pkg.sv
hw/memory_controller.sv
hw/data_ram.sv
hw/video_controller.sv
hw/tmds_encoder.sv
hw/video_soc_top.sv
tb/tb_video_soc.sv

/* hw/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input wire clk_in,

    input wire soc_pkg::word_t    addr,
    input wire soc_pkg::word_t    wdata,
    input wire soc_pkg::byte_en_t we,
    output soc_pkg::word_t        rdata
);
    import soc_pkg::*;

    word_t                    mem [RAM_WORDS];
    logic [RAM_ADDR_BITS-1:0] index;

    // word addressed, byte offset bits dropped
    assign index = addr[RAM_ADDR_BITS+1:2];

    ////////////////////////////////////////////////////////////
    // write port

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                mem[index][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read port

    // old contents on a same-cycle write
    always_ff @(posedge clk_in) begin
        rdata <= mem[index];
    end

endmodule

`default_nettype wire

/* hw/memory_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_controller (
    input wire clk_in,
    input wire rst_n,

    // cpu side
    input wire soc_pkg::word_t    cpu_addr,
    input wire soc_pkg::word_t    cpu_wdata,
    input wire soc_pkg::byte_en_t cpu_we,
    output soc_pkg::word_t        cpu_rdata,

    // data ram
    output soc_pkg::word_t        ram_addr,
    output soc_pkg::word_t        ram_wdata,
    output soc_pkg::byte_en_t     ram_we,
    input wire soc_pkg::word_t    ram_rdata,

    // framebuffer
    output soc_pkg::word_t        fb_addr,
    output soc_pkg::word_t        fb_wdata,
    output soc_pkg::byte_en_t     fb_we,
    input wire soc_pkg::word_t    fb_rdata
);
    import soc_pkg::*;

    region_t region;
    logic    sel_ram, sel_fb;
    logic    sel_ram_q, sel_fb_q;    // selection of the previous request

    assign region  = region_t'(cpu_addr[31:28]);
    assign sel_ram = (region == REGION_RAM);
    assign sel_fb  = (region == REGION_VIDEO);

    // address and data go everywhere, only the enables are steered
    assign ram_addr  = cpu_addr;
    assign ram_wdata = cpu_wdata;
    assign ram_we    = sel_ram ? cpu_we : '0;

    assign fb_addr   = cpu_addr;
    assign fb_wdata  = cpu_wdata;
    assign fb_we     = sel_fb ? cpu_we : '0;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            sel_ram_q <= 1'b0;
            sel_fb_q  <= 1'b0;
        end else begin
            sel_ram_q <= sel_ram;
            sel_fb_q  <= sel_fb;
        end
    end

    // both targets answer one cycle later, pick the one asked
    always_comb begin
        if (sel_ram_q) begin
            cpu_rdata = ram_rdata;
        end else if (sel_fb_q) begin
            cpu_rdata = fb_rdata;
        end else begin
            cpu_rdata = '0;              // unmapped
        end
    end

endmodule

`default_nettype wire

/* hw/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    ////////////////////////////////////////////////////////////
    // bus and video types

    typedef logic [31:0]       word_t;       // bus address or data
    typedef logic [3:0]        byte_en_t;    // one bit per byte lane
    typedef logic [3:0]        region_t;     // address bits 31:28
    typedef logic [7:0]        channel_t;    // 8-bit colour channel
    typedef logic [7:0]        pixel_t;      // rgb332, red on top
    typedef logic [9:0]        tmds_word_t;
    typedef logic signed [4:0] disparity_t;  // running dc balance

    ////////////////////////////////////////////////////////////
    // address map

    localparam region_t REGION_RAM   = 4'h0;
    localparam region_t REGION_VIDEO = 4'h2;

    localparam int RAM_WORDS     = 256;
    localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);
    localparam int FB_WORDS      = 32;       // four pixels per word
    localparam int FB_ADDR_BITS  = $clog2(FB_WORDS);

    typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;

    ////////////////////////////////////////////////////////////
    // raster timing, tiny on purpose

    localparam int H_ACTIVE = 16;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;

    localparam int V_ACTIVE = 8;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    typedef logic [$clog2(H_TOTAL)-1:0] hcount_t;
    typedef logic [$clog2(V_TOTAL)-1:0] vcount_t;

    // dvi control symbols, index is {c1, c0}
    localparam tmds_word_t CTRL_00 = 10'b1101010100;
    localparam tmds_word_t CTRL_01 = 10'b0010101011;
    localparam tmds_word_t CTRL_10 = 10'b0101010100;
    localparam tmds_word_t CTRL_11 = 10'b1010101011;

endpackage

`default_nettype wire

/* hw/tmds_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder (
    input wire clk_in,
    input wire rst_n,

    input wire soc_pkg::channel_t data,
    input wire [1:0]              ctrl,         // {c1, c0}
    input wire                    active_draw,
    output soc_pkg::tmds_word_t   tmds
);
    import soc_pkg::*;

    logic [3:0] ones_data;
    logic       use_xnor;
    logic [8:0] q_m;             // transition minimised word
    logic [3:0] ones_qm, zeros_qm;
    disparity_t balance;         // ones minus zeros of q_m[7:0]
    disparity_t disparity;
    tmds_word_t ctrl_code;

    ////////////////////////////////////////////////////////////
    // stage 1, xor or xnor chain

    always_comb begin
        ones_data = '0;
        for (int i = 0; i < 8; i++) begin
            ones_data = ones_data + 4'(data[i]);
        end
        use_xnor = (ones_data > 4'd4) || ((ones_data == 4'd4) && !data[0]);
        q_m[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        q_m[8] = ~use_xnor;
    end

    ////////////////////////////////////////////////////////////
    // stage 2, dc balance

    always_comb begin
        ones_qm = '0;
        for (int i = 0; i < 8; i++) begin
            ones_qm = ones_qm + 4'(q_m[i]);
        end
        zeros_qm = 4'd8 - ones_qm;
        balance  = disparity_t'({1'b0, ones_qm}) - disparity_t'({1'b0, zeros_qm});
    end

    always_comb begin
        case (ctrl)
            2'b00:   ctrl_code = CTRL_00;
            2'b01:   ctrl_code = CTRL_01;
            2'b10:   ctrl_code = CTRL_10;
            default: ctrl_code = CTRL_11;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            tmds      <= CTRL_00;
            disparity <= '0;
        end else if (!active_draw) begin
            tmds      <= ctrl_code;
            disparity <= '0;                 // restart balance each line
        end else if ((disparity == 0) || (ones_qm == zeros_qm)) begin
            tmds <= {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            if (q_m[8]) begin
                disparity <= disparity + balance;
            end else begin
                disparity <= disparity - balance;
            end
        end else if (((disparity > 0) && (ones_qm > zeros_qm)) ||
                     ((disparity < 0) && (zeros_qm > ones_qm))) begin
            // invert to pull the balance back
            tmds      <= {1'b1, q_m[8], ~q_m[7:0]};
            disparity <= disparity + disparity_t'({q_m[8], 1'b0}) - balance;
        end else begin
            tmds      <= {1'b0, q_m[8], q_m[7:0]};
            disparity <= disparity - disparity_t'({~q_m[8], 1'b0}) + balance;
        end
    end

endmodule

`default_nettype wire

/* hw/video_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module video_controller (
    input wire clk_in,
    input wire rst_n,

    // cpu port into the framebuffer
    input wire soc_pkg::word_t    cpu_addr,
    input wire soc_pkg::word_t    cpu_wdata,
    input wire soc_pkg::byte_en_t cpu_we,
    output soc_pkg::word_t        cpu_rdata,

    // pixel stream
    output soc_pkg::channel_t     red,
    output soc_pkg::channel_t     green,
    output soc_pkg::channel_t     blue,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  active_draw
);
    import soc_pkg::*;

    hcount_t  h_count;
    vcount_t  v_count;
    logic     active_raw, hsync_raw, vsync_raw;

    word_t    fb_mem [FB_WORDS];
    fb_addr_t cpu_index;
    fb_addr_t pix_index;

    word_t    fb_word_q;           // stage 1
    logic [1:0] lane_q;
    logic     active_q, hsync_q, vsync_q;

    pixel_t   pix;
    channel_t red_wide, green_wide, blue_wide;

    ////////////////////////////////////////////////////////////
    // raster counters

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == hcount_t'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == vcount_t'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // active, front porch, sync, back porch
    assign active_raw = (h_count < hcount_t'(H_ACTIVE)) && (v_count < vcount_t'(V_ACTIVE));
    assign hsync_raw  = (h_count >= hcount_t'(H_SYNC_START)) &&
                        (h_count <  hcount_t'(H_SYNC_END));
    assign vsync_raw  = (v_count >= vcount_t'(V_SYNC_START)) &&
                        (v_count <  vcount_t'(V_SYNC_END));

    ////////////////////////////////////////////////////////////
    // framebuffer, cpu side

    assign cpu_index = cpu_addr[FB_ADDR_BITS+1:2];

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < 4; i++) begin
            if (cpu_we[i]) begin
                fb_mem[cpu_index][8*i +: 8] <= cpu_wdata[8*i +: 8];
            end
        end
        cpu_rdata <= fb_mem[cpu_index];
    end

    ////////////////////////////////////////////////////////////
    // pixel pipeline

    // four pixels per word, x mod 4 picks the lane
    assign pix_index = fb_addr_t'((v_count * H_ACTIVE + h_count) / 4);

    always_ff @(posedge clk_in) begin
        fb_word_q <= fb_mem[pix_index];
        lane_q    <= h_count[1:0];
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            hsync_q  <= 1'b0;
            vsync_q  <= 1'b0;
        end else begin
            active_q <= active_raw;
            hsync_q  <= hsync_raw;
            vsync_q  <= vsync_raw;
        end
    end

    assign pix = fb_word_q[8*lane_q +: 8];

    // rgb332 to 8 bits by bit repetition
    assign red_wide   = {pix[7:5], pix[7:5], pix[7:6]};
    assign green_wide = {pix[4:2], pix[4:2], pix[4:3]};
    assign blue_wide  = {4{pix[1:0]}};

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            red         <= '0;
            green       <= '0;
            blue        <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            active_draw <= 1'b0;
        end else begin
            red         <= active_q ? red_wide   : '0;   // black in blanking
            green       <= active_q ? green_wide : '0;
            blue        <= active_q ? blue_wide  : '0;
            hsync       <= hsync_q;
            vsync       <= vsync_q;
            active_draw <= active_q;
        end
    end

endmodule

`default_nettype wire

/* hw/video_soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_soc_top (
    input wire clk_in,
    input wire rst_n,

    input wire soc_pkg::word_t    cpu_addr,
    input wire soc_pkg::word_t    cpu_wdata,
    input wire soc_pkg::byte_en_t cpu_we,
    output soc_pkg::word_t        cpu_rdata,

    output soc_pkg::tmds_word_t   tmds_red,
    output soc_pkg::tmds_word_t   tmds_green,
    output soc_pkg::tmds_word_t   tmds_blue
);
    import soc_pkg::*;

    // memory controller to targets
    word_t    ram_addr, ram_wdata, ram_rdata;
    byte_en_t ram_we;
    word_t    fb_addr, fb_wdata, fb_rdata;
    byte_en_t fb_we;

    // pixel stream
    channel_t video_red, video_green, video_blue;
    logic     video_hsync, video_vsync, video_active_draw;

    ////////////////////////////////////////////////////////////
    // memory and peripherals

    memory_controller memory_ctrl (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata),
        .cpu_we(cpu_we),
        .cpu_rdata(cpu_rdata),
        .ram_addr(ram_addr),
        .ram_wdata(ram_wdata),
        .ram_we(ram_we),
        .ram_rdata(ram_rdata),
        .fb_addr(fb_addr),
        .fb_wdata(fb_wdata),
        .fb_we(fb_we),
        .fb_rdata(fb_rdata)
    );

    data_ram data_memory (
        .clk_in(clk_in),
        .addr(ram_addr),
        .wdata(ram_wdata),
        .we(ram_we),
        .rdata(ram_rdata)
    );

    video_controller mvc (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .cpu_addr(fb_addr),
        .cpu_wdata(fb_wdata),
        .cpu_we(fb_we),
        .cpu_rdata(fb_rdata),
        .red(video_red),
        .green(video_green),
        .blue(video_blue),
        .hsync(video_hsync),
        .vsync(video_vsync),
        .active_draw(video_active_draw)
    );

    ////////////////////////////////////////////////////////////
    // tmds, syncs ride on blue only

    tmds_encoder tmds_encoder_red (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .data(video_red),
        .ctrl(2'b00),
        .active_draw(video_active_draw),
        .tmds(tmds_red)
    );

    tmds_encoder tmds_encoder_green (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .data(video_green),
        .ctrl(2'b00),
        .active_draw(video_active_draw),
        .tmds(tmds_green)
    );

    tmds_encoder tmds_encoder_blue (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .data(video_blue),
        .ctrl({video_vsync, video_hsync}),
        .active_draw(video_active_draw),
        .tmds(tmds_blue)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module tb_video_soc -f build.f -o tb_video_soc \
    && ./obj_dir/tb_video_soc > sim.log 2>&1 \
    || echo "build or simulation run did not complete"

cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb/tmds_checker.svh */
    ////////////////////////////////////////////////////////////
    // tmds decoding and raster tracking for the stream checks

    int   data_words = 0;                 // since the end of the last vsync run
    int   frames_checked = 0;
    int   hsync_words = 0;
    int   hsync_runs = 0;                 // closed since the end of the last vsync run
    int   vsync_words = 0;
    int   line_balance [3] = '{0, 0, 0};  // ones minus zeros per channel
    logic frame_valid = 1'b0;             // frame drawn from a settled framebuffer

    function automatic logic is_ctrl(tmds_word_t w);
        return (w == CTRL_00) || (w == CTRL_01) || (w == CTRL_10) || (w == CTRL_11);
    endfunction

    // {vsync, hsync} carried by a blue control code
    function automatic logic [1:0] sync_bits(tmds_word_t w);
        return {(w == CTRL_10) || (w == CTRL_11), (w == CTRL_01) || (w == CTRL_11)};
    endfunction

    // undo the inversion and then the xor or xnor chain
    function automatic channel_t tmds_decode(tmds_word_t w);
        logic [7:0] q;
        channel_t   d;
        q    = w[9] ? ~w[7:0] : w[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = w[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        return d;
    endfunction

    // re-encoding the decoded byte must rebuild the same word
    function automatic logic legal_word(tmds_word_t w);
        channel_t   d;
        logic [8:0] q;
        logic       xnor_mode;
        d         = tmds_decode(w);
        xnor_mode = ($countones(d) > 4) || (($countones(d) == 4) && !d[0]);
        q[0]      = d[0];
        for (int i = 1; i < 8; i++) begin
            q[i] = xnor_mode ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
        end
        q[8] = !xnor_mode;
        return w == {w[9], q[8], w[9] ? ~q[7:0] : q[7:0]};
    endfunction

    function automatic int word_balance(tmds_word_t w);
        return 2 * $countones(w) - 10;
    endfunction

/* tb/tb_video_soc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_video_soc;
    import soc_pkg::*;

    localparam int RAM_SLOTS       = 16;
    localparam int FRAMES_TO_CHECK = 3;
    // about 250 bus cycles and up to four frames of H_TOTAL * V_TOTAL
    localparam int TIMEOUT_CYCLES  = 5000;

    logic       clk_in = 1'b0;
    logic       rst_n;
    word_t      cpu_addr, cpu_wdata, cpu_rdata;
    byte_en_t   cpu_we;
    tmds_word_t tmds_red, tmds_green, tmds_blue;

    int         seed = 32'h47b8b458;
    int         cycles = 0;
    int         bus_errors = 0;
    int         video_errors = 0;
    logic       fb_stable = 1'b0;        // cpu is done with the framebuffer
    word_t      ram_shadow [RAM_WORDS];
    word_t      fb_shadow [FB_WORDS];
    logic [7:0] ram_slot [RAM_SLOTS];
    string      ch_name [3] = '{"red", "green", "blue"};

    // read data owed for the request one cycle back
    logic       prev_check = 1'b0;
    word_t      prev_exp;
    string      prev_name;

    `include "tmds_checker.svh"

    video_soc_top uut (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata),
        .cpu_we(cpu_we),
        .cpu_rdata(cpu_rdata),
        .tmds_red(tmds_red),
        .tmds_green(tmds_green),
        .tmds_blue(tmds_blue)
    );

    always #4 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles, %0d frames checked",
                     TIMEOUT_CYCLES, frames_checked);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // bus helpers

    function automatic word_t bus_addr(region_t region, logic [7:0] index);
        return {region, 18'h0, index, 2'b00};
    endfunction

    function automatic word_t merge_lanes(word_t old, word_t wdata, byte_en_t we);
        word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    // rgb332 field widened by repeating its bits
    function automatic channel_t widen3(logic [2:0] f);
        return {f, f, f[2:1]};
    endfunction

    // one request per cycle with the previous read checked mid-cycle
    task automatic bus_cycle(input word_t addr, input word_t wdata, input byte_en_t we,
                             input logic check, input word_t exp, input string name);
        @(posedge clk_in);
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        cpu_we    <= we;
        @(negedge clk_in);
        if (prev_check) begin
            assert (cpu_rdata === prev_exp) else begin
                $display("MISMATCH %s: expected %h actual %h", prev_name, prev_exp, cpu_rdata);
                bus_errors++;
            end
        end
        prev_check = check;
        prev_exp   = exp;
        prev_name  = name;
    endtask

    task automatic bus_write(input word_t addr, input word_t wdata, input byte_en_t we);
        bus_cycle(addr, wdata, we, 1'b0, '0, "");
    endtask

    task automatic bus_read(input word_t addr, input word_t exp, input string name);
        bus_cycle(addr, '0, '0, 1'b1, exp, name);
    endtask

    ////////////////////////////////////////////////////////////
    // cpu side sequence

    initial begin
        word_t      data;
        byte_en_t   we;
        logic [7:0] slot;
        fb_addr_t   fb_slot;
        rst_n     = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_we    = '0;
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        assert ((cpu_rdata === '0) && (tmds_red === CTRL_00) &&
                (tmds_green === CTRL_00) && (tmds_blue === CTRL_00)) else begin
            $display("outputs are not at their reset values while rst_n is low");
            bus_errors++;
        end
        @(posedge clk_in);
        rst_n <= 1'b1;

        // ram slots start fully written so the shadow is known
        for (int i = 0; i < RAM_SLOTS; i++) begin
            ram_slot[i] = 8'($random(seed));
            data        = $random(seed);
            ram_shadow[ram_slot[i]] = data;
            bus_write(bus_addr(REGION_RAM, ram_slot[i]), data, 4'hf);
        end
        for (int i = 0; i < 48; i++) begin
            slot = ram_slot[4'($random(seed))];
            data = $random(seed);
            we   = 4'($random(seed));
            if (we == 4'h0) begin
                we = 4'h8;                   // keep it a write
            end
            ram_shadow[slot] = merge_lanes(ram_shadow[slot], data, we);
            bus_write(bus_addr(REGION_RAM, slot), data, we);
            slot = ram_slot[4'($random(seed))];
            bus_read(bus_addr(REGION_RAM, slot), ram_shadow[slot], "ram_lanes");
        end

        // framebuffer fill and then scattered lane writes
        for (int i = 0; i < FB_WORDS; i++) begin
            fb_shadow[i] = $random(seed);
            bus_write(bus_addr(REGION_VIDEO, 8'(i)), fb_shadow[i], 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            fb_slot = fb_addr_t'($random(seed));
            data    = $random(seed);
            we      = 4'($random(seed));
            fb_shadow[fb_slot] = merge_lanes(fb_shadow[fb_slot], data, we);
            bus_write(bus_addr(REGION_VIDEO, 8'(fb_slot)), data, we);
        end

        // region 5 is unmapped but shares its low address bits with the ram slots
        for (int i = 0; i < RAM_SLOTS; i++) begin
            bus_write(bus_addr(4'h5, ram_slot[i]), $random(seed), 4'hf);
            bus_read(bus_addr(4'h5, ram_slot[i]), '0, "unmapped_read");
        end

        for (int i = 0; i < FB_WORDS; i++) begin
            bus_read(bus_addr(REGION_VIDEO, 8'(i)), fb_shadow[i], "fb_readback");
        end
        for (int i = 0; i < RAM_SLOTS; i++) begin
            bus_read(bus_addr(REGION_RAM, ram_slot[i]), ram_shadow[ram_slot[i]],
                     "ram_after_unmapped");
        end
        bus_write(bus_addr(4'h5, 8'h0), '0, '0);    // idle request lets the last read land

        @(posedge clk_in);
        fb_stable = 1'b1;
        wait (frames_checked >= FRAMES_TO_CHECK);
        @(posedge clk_in);
        $display("bus errors %0d, video errors %0d, frames checked %0d",
                 bus_errors, video_errors, frames_checked);
        if ((bus_errors == 0) && (video_errors == 0)) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // tmds stream with one word per channel per cycle

    always @(negedge clk_in) begin
        tmds_word_t words [3];
        channel_t   expected [3];
        pixel_t     pixel;
        logic [1:0] sync;
        int         x;
        int         y;
        words    = '{tmds_red, tmds_green, tmds_blue};
        x        = data_words % H_ACTIVE;
        y        = data_words / H_ACTIVE;
        pixel    = pixel_t'(fb_shadow[fb_addr_t'((y * H_ACTIVE + x) / 4)] >> (8 * (x % 4)));
        expected = '{widen3(pixel[7:5]), widen3(pixel[4:2]), {4{pixel[1:0]}}};
        sync     = sync_bits(tmds_blue);
        if (rst_n && !is_ctrl(tmds_blue)) begin
            for (int c = 0; c < 3; c++) begin
                assert (legal_word(words[c])) else begin
                    $display("%s sent %h, which is no legal TMDS data word",
                             ch_name[c], words[c]);
                    video_errors++;
                end
                if (frame_valid && (y < V_ACTIVE)) begin
                    assert (tmds_decode(words[c]) === expected[c]) else begin
                        $display("MISMATCH pixel_%s at (%0d,%0d): expected %h actual %h",
                                 ch_name[c], x, y, expected[c], tmds_decode(words[c]));
                        video_errors++;
                    end
                end
                line_balance[c] += word_balance(words[c]);
            end
            data_words++;
        end else if (rst_n) begin
            for (int c = 0; c < 3; c++) begin
                assert ((line_balance[c] >= -20) && (line_balance[c] <= 20)) else begin
                    $display("%s line is out of DC balance by %0d", ch_name[c], line_balance[c]);
                    video_errors++;
                end
                line_balance[c] = 0;
            end
            for (int c = 0; c < 2; c++) begin
                assert (words[c] === CTRL_00) else begin
                    $display("MISMATCH blank_%s: expected %h actual %h",
                             ch_name[c], CTRL_00, words[c]);
                    video_errors++;
                end
            end
            if (sync[0]) begin
                hsync_words++;
            end else if (hsync_words != 0) begin
                assert (hsync_words == H_SYNC) else begin
                    $display("MISMATCH hsync_run: expected %0d actual %0d", H_SYNC, hsync_words);
                    video_errors++;
                end
                hsync_words = 0;
                hsync_runs++;
            end
            // vsync start closes a frame and its end opens the next one
            if (sync[1]) begin
                if ((vsync_words == 0) && frame_valid) begin
                    assert (data_words == H_ACTIVE * V_ACTIVE) else begin
                        $display("MISMATCH frame_data_words: expected %0d actual %0d",
                                 H_ACTIVE * V_ACTIVE, data_words);
                        video_errors++;
                    end
                    // one hsync run on every line outside the vsync lines
                    assert (hsync_runs == V_TOTAL - V_SYNC) else begin
                        $display("MISMATCH frame_hsync_runs: expected %0d actual %0d",
                                 V_TOTAL - V_SYNC, hsync_runs);
                        video_errors++;
                    end
                    frames_checked++;
                    frame_valid = 1'b0;
                end
                vsync_words++;
            end else if (vsync_words != 0) begin
                assert (vsync_words == V_SYNC * H_TOTAL) else begin
                    $display("MISMATCH vsync_words: expected %0d actual %0d",
                             V_SYNC * H_TOTAL, vsync_words);
                    video_errors++;
                end
                vsync_words = 0;
                data_words  = 0;
                hsync_runs  = 0;
                frame_valid = fb_stable;
            end
        end
    end

endmodule

`default_nettype wire
